// File: verilog/lsu_macros.svh
// Load/store unit widths
// Data path, register name and data memory sizes shared by all blocks
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Data word and byte address width
`define LSU_DATA_W 32

// Destination register name width
`define LSU_REG_W 6

// Data memory depth in words
`define LSU_MEM_WORDS 256

// Word address bits above the byte lanes
`define LSU_MEM_AW 8

`endif

// File: verilog/lsu_cmd_pkg.sv
// Load/store command types
// Scheduler-side command, access size and commit tag
`default_nettype none

package lsu_cmd_pkg;

	typedef enum logic [3:0] {
		LD_BYTE   = 4'h0,
		LD_HALF   = 4'h1,
		LD_WORD   = 4'h2,
		ST_BYTE   = 4'h3,
		ST_HALF   = 4'h4,
		ST_WORD   = 4'h5,
		PUSH      = 4'h6,
		POP       = 4'h7,
		WRITE_SPR = 4'h8
	} ldst_cmd_t;

	typedef enum logic [1:0] {
		SIZE_BYTE = 2'h0,
		SIZE_HALF = 2'h1,
		SIZE_WORD = 2'h2
	} access_size_t;

	typedef logic [5:0] commit_tag_t;

	// Stack and SPR commands move whole words
	function automatic access_size_t cmd_size(input ldst_cmd_t cmd);
		case (cmd)
			LD_BYTE, ST_BYTE: return SIZE_BYTE;
			LD_HALF, ST_HALF: return SIZE_HALF;
			default: return SIZE_WORD;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: verilog/lsu_bus_pkg.sv
// Data bus types
// Access order on the memory bus and the requester index of the arbiter
`default_nettype none

package lsu_bus_pkg;

	// Same encoding as the data port order field
	typedef enum logic [1:0] {
		ORDER_BYTE = 2'b00,
		ORDER_HALF = 2'b01,
		ORDER_WORD = 2'b10,
		ORDER_NONE = 2'b11
	} mem_order_t;

	typedef logic port_index_t;

	localparam port_index_t PORT_0 = 1'b0;
	localparam port_index_t PORT_1 = 1'b1;

endpackage

`default_nettype wire

// File: verilog/ldst_address_gen.sv
// Load/store address generation
// Turns one command into a bus access and the matching SPR update
`timescale 1ns/100ps
`default_nettype none
`include "lsu_macros.svh"

module ldst_address_gen
	import lsu_cmd_pkg::*;
	import lsu_bus_pkg::*;
(
	input wire ldst_cmd_t cmd,
	input wire [`LSU_DATA_W-1:0] source0,
	input wire [`LSU_DATA_W-1:0] source1,
	input wire [`LSU_DATA_W-1:0] spr,
	output logic rw,
	output logic [`LSU_DATA_W-1:0] addr,
	output logic [`LSU_DATA_W-1:0] store_data,
	output logic [`LSU_DATA_W-1:0] new_spr,
	output logic spr_write,
	output logic [3:0] mask,
	output mem_order_t order,
	output logic [1:0] lane_shift
);

	localparam logic [`LSU_DATA_W-1:0] WORD_BYTES = 4;

	access_size_t size;

	assign size = cmd_size(cmd);
	assign rw = cmd inside {ST_BYTE, ST_HALF, ST_WORD, PUSH};
	assign spr_write = cmd inside {PUSH, POP, WRITE_SPR};

	// Stack grows downward, PUSH pre-decrements and POP post-increments
	always_comb begin
		addr = source1;
		new_spr = spr;
		case (cmd)
			PUSH: begin
				addr = spr - WORD_BYTES;
				new_spr = spr - WORD_BYTES;
			end
			POP: begin
				addr = spr;
				new_spr = spr + WORD_BYTES;
			end
			WRITE_SPR: new_spr = source0;
			default: new_spr = spr;
		endcase
	end

	// Lane select; replicated store data already sits in every lane
	always_comb begin
		order = ORDER_WORD;
		lane_shift = 2'd0;
		mask = 4'b1111;
		store_data = source0;
		if (cmd == WRITE_SPR) begin
			order = ORDER_NONE;
			mask = 4'b0000;
		end else if (size == SIZE_BYTE) begin
			order = ORDER_BYTE;
			lane_shift = addr[1:0];
			mask = 4'b0001 << addr[1:0];
			store_data = {4{source0[7:0]}};
		end else if (size == SIZE_HALF) begin
			order = ORDER_HALF;
			lane_shift = {addr[1], 1'b0};
			mask = 4'b0011 << {addr[1], 1'b0};
			store_data = {2{source0[15:0]}};
		end
	end

endmodule

`default_nettype wire

// File: verilog/ldst_port.sv
// Load/store execution port
// One command at a time, owns the SPR and reports completion with done
`timescale 1ns/100ps
`default_nettype none
`include "lsu_macros.svh"

module ldst_port
	import lsu_cmd_pkg::*;
	import lsu_bus_pkg::*;
(
	input wire iCLOCK,
	input wire inRESET,
	input wire issue_valid,
	input wire ldst_cmd_t cmd,
	input wire [`LSU_DATA_W-1:0] source0,
	input wire [`LSU_DATA_W-1:0] source1,
	input wire commit_tag_t commit_tag,
	input wire [`LSU_REG_W-1:0] dest_reg,
	input wire bus_busy,
	input wire bus_ack,
	input wire [`LSU_DATA_W-1:0] bus_rdata,
	output logic lock,
	output logic done,
	output commit_tag_t done_tag,
	output logic [`LSU_REG_W-1:0] done_reg,
	output logic writeback,
	output logic [`LSU_DATA_W-1:0] done_data,
	output logic [`LSU_DATA_W-1:0] spr,
	output logic bus_req,
	output logic bus_rw,
	output logic [`LSU_DATA_W-1:0] bus_addr,
	output logic [`LSU_DATA_W-1:0] bus_data,
	output logic [3:0] bus_mask,
	output mem_order_t bus_order
);

	typedef enum logic [2:0] {
		ST_IDLE    = 3'h0,
		ST_LDREQ   = 3'h1,
		ST_LDWAIT  = 3'h2,
		ST_STREQ   = 3'h3,
		ST_STWAIT  = 3'h4,
		ST_SPRWAIT = 3'h5
	} state_t;

	state_t b_state;
	logic b_spr_step;
	logic [`LSU_DATA_W-1:0] b_spr;

	logic gen_rw;
	logic [`LSU_DATA_W-1:0] gen_addr;
	logic [`LSU_DATA_W-1:0] gen_data;
	logic [`LSU_DATA_W-1:0] gen_new_spr;
	logic gen_spr_write;
	logic [3:0] gen_mask;
	mem_order_t gen_order;
	logic [1:0] gen_shift;

	logic [1:0] b_shift;
	logic [`LSU_DATA_W-1:0] load_shifted;
	logic issue_fire;

	ldst_address_gen u_address_gen (
		.cmd(cmd),
		.source0(source0),
		.source1(source1),
		.spr(b_spr),
		.rw(gen_rw),
		.addr(gen_addr),
		.store_data(gen_data),
		.new_spr(gen_new_spr),
		.spr_write(gen_spr_write),
		.mask(gen_mask),
		.order(gen_order),
		.lane_shift(gen_shift)
	);

	assign lock = (b_state != ST_IDLE) || bus_busy;
	assign issue_fire = issue_valid && !lock;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_state <= ST_IDLE;
			b_spr_step <= 1'b0;
		end else begin
			case (b_state)
				ST_IDLE: begin
					b_spr_step <= 1'b0;
					if (issue_fire) begin
						if (gen_order == ORDER_NONE) begin
							b_state <= ST_SPRWAIT;
						end else if (gen_rw) begin
							b_state <= ST_STREQ;
						end else begin
							b_state <= ST_LDREQ;
						end
					end
				end
				ST_LDREQ: if (!bus_busy) b_state <= ST_LDWAIT;
				ST_LDWAIT: if (bus_ack) b_state <= ST_IDLE;
				ST_STREQ: if (!bus_busy) b_state <= ST_STWAIT;
				ST_STWAIT: if (bus_ack) b_state <= ST_IDLE;
				// Two cycles so SPR writes finish like a bus access
				ST_SPRWAIT: begin
					b_spr_step <= 1'b1;
					if (b_spr_step) begin
						b_state <= ST_IDLE;
					end
				end
				default: b_state <= ST_IDLE;
			endcase
		end
	end

	// SPR takes its new value at issue
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_spr <= '0;
		end else if (issue_fire && gen_spr_write) begin
			b_spr <= gen_new_spr;
		end
	end

	// Request and completion fields held for the whole command
	always_ff @(posedge iCLOCK) begin
		if (issue_fire) begin
			bus_rw <= gen_rw;
			bus_addr <= gen_addr;
			bus_data <= gen_data;
			bus_mask <= gen_mask;
			bus_order <= gen_order;
			b_shift <= gen_shift;
			done_tag <= commit_tag;
			done_reg <= dest_reg;
		end
	end

	assign bus_req = (b_state == ST_LDREQ) || (b_state == ST_STREQ);
	assign spr = b_spr;

	// Load lanes down to bit 0, then zero-extend by order
	assign load_shifted = bus_rdata >> {b_shift, 3'b000};

	always_comb begin
		case (bus_order)
			ORDER_BYTE: done_data = {{(`LSU_DATA_W-8){1'b0}}, load_shifted[7:0]};
			ORDER_HALF: done_data = {{(`LSU_DATA_W-16){1'b0}}, load_shifted[15:0]};
			default: done_data = load_shifted;
		endcase
	end

	assign done = (((b_state == ST_LDWAIT) || (b_state == ST_STWAIT)) && bus_ack)
		|| ((b_state == ST_SPRWAIT) && b_spr_step);
	assign writeback = (b_state == ST_LDWAIT);

endmodule

`default_nettype wire

// File: verilog/data_bus_arbiter.sv
// Data bus arbiter
// Round-robin sharing of the data memory between two load/store ports
`timescale 1ns/100ps
`default_nettype none
`include "lsu_macros.svh"

module data_bus_arbiter
	import lsu_bus_pkg::*;
(
	input wire iCLOCK,
	input wire inRESET,
	input wire req0,
	input wire req1,
	input wire rw0,
	input wire rw1,
	input wire [`LSU_DATA_W-1:0] addr0,
	input wire [`LSU_DATA_W-1:0] addr1,
	input wire [`LSU_DATA_W-1:0] data0,
	input wire [`LSU_DATA_W-1:0] data1,
	input wire [3:0] mask0,
	input wire [3:0] mask1,
	input wire mem_ack,
	input wire [`LSU_DATA_W-1:0] mem_rdata,
	output logic busy0,
	output logic busy1,
	output logic ack0,
	output logic ack1,
	output logic [`LSU_DATA_W-1:0] rdata,
	output logic mem_en,
	output logic mem_rw,
	output logic [`LSU_DATA_W-1:0] mem_addr,
	output logic [`LSU_DATA_W-1:0] mem_wdata,
	output logic [3:0] mem_mask
);

	port_index_t b_last;
	port_index_t b_owner;
	port_index_t pick;
	logic b_in_flight;
	logic both;

	assign both = req0 && req1;

	// On a tie the port not served last wins
	always_comb begin
		if (both) begin
			pick = ~b_last;
		end else if (req1) begin
			pick = PORT_1;
		end else begin
			pick = PORT_0;
		end
	end

	assign mem_en = !b_in_flight && (req0 || req1);
	assign mem_rw = (pick == PORT_1) ? rw1 : rw0;
	assign mem_addr = (pick == PORT_1) ? addr1 : addr0;
	assign mem_wdata = (pick == PORT_1) ? data1 : data0;
	assign mem_mask = (pick == PORT_1) ? mask1 : mask0;

	assign busy0 = b_in_flight || (both && (pick == PORT_1));
	assign busy1 = b_in_flight || (both && (pick == PORT_0));

	assign ack0 = mem_ack && (b_owner == PORT_0);
	assign ack1 = mem_ack && (b_owner == PORT_1);
	assign rdata = mem_rdata;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_last <= PORT_1;
			b_owner <= PORT_0;
			b_in_flight <= 1'b0;
		end else begin
			b_in_flight <= mem_en;
			if (mem_en) begin
				b_last <= pick;
				b_owner <= pick;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/data_memory.sv
// Data memory
// Word array with byte-masked writes and one-cycle registered reads
`timescale 1ns/100ps
`default_nettype none
`include "lsu_macros.svh"

module data_memory (
	input wire iCLOCK,
	input wire inRESET,
	input wire mem_en,
	input wire mem_rw,
	input wire [`LSU_DATA_W-1:0] mem_addr,
	input wire [`LSU_DATA_W-1:0] mem_wdata,
	input wire [3:0] mem_mask,
	output logic mem_ack,
	output logic [`LSU_DATA_W-1:0] mem_rdata
);

	logic [`LSU_DATA_W-1:0] mem [`LSU_MEM_WORDS];
	logic [`LSU_MEM_AW-1:0] word_addr;

	// Byte lanes sit below the word index
	assign word_addr = mem_addr[`LSU_MEM_AW+1:2];

	always_ff @(posedge iCLOCK) begin
		if (mem_en) begin
			if (mem_rw) begin
				for (int i = 0; i < 4; i++) begin
					if (mem_mask[i]) begin
						mem[word_addr][8*i +: 8] <= mem_wdata[8*i +: 8];
					end
				end
			end else begin
				mem_rdata <= mem[word_addr];
			end
		end
	end

	// Every access, read or write, is acked next cycle
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			mem_ack <= 1'b0;
		end else begin
			mem_ack <= mem_en;
		end
	end

endmodule

`default_nettype wire

// File: verilog/lsu_top.sv
// Load/store subsystem
// Two load/store ports sharing one data memory through the arbiter
`timescale 1ns/100ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_top
	import lsu_cmd_pkg::*;
(
	input wire iCLOCK,
	input wire inRESET,
	input wire issue_valid_0,
	input wire ldst_cmd_t cmd_0,
	input wire [`LSU_DATA_W-1:0] source0_0,
	input wire [`LSU_DATA_W-1:0] source1_0,
	input wire commit_tag_t commit_tag_0,
	input wire [`LSU_REG_W-1:0] dest_reg_0,
	output logic lock_0,
	output logic done_0,
	output commit_tag_t done_tag_0,
	output logic [`LSU_REG_W-1:0] done_reg_0,
	output logic writeback_0,
	output logic [`LSU_DATA_W-1:0] done_data_0,
	output logic [`LSU_DATA_W-1:0] spr_0,
	input wire issue_valid_1,
	input wire ldst_cmd_t cmd_1,
	input wire [`LSU_DATA_W-1:0] source0_1,
	input wire [`LSU_DATA_W-1:0] source1_1,
	input wire commit_tag_t commit_tag_1,
	input wire [`LSU_REG_W-1:0] dest_reg_1,
	output logic lock_1,
	output logic done_1,
	output commit_tag_t done_tag_1,
	output logic [`LSU_REG_W-1:0] done_reg_1,
	output logic writeback_1,
	output logic [`LSU_DATA_W-1:0] done_data_1,
	output logic [`LSU_DATA_W-1:0] spr_1
);

	logic bus_req_0, bus_req_1;
	logic bus_rw_0, bus_rw_1;
	logic [`LSU_DATA_W-1:0] bus_addr_0, bus_addr_1;
	logic [`LSU_DATA_W-1:0] bus_data_0, bus_data_1;
	logic [3:0] bus_mask_0, bus_mask_1;
	logic bus_busy_0, bus_busy_1;
	logic bus_ack_0, bus_ack_1;
	logic [`LSU_DATA_W-1:0] bus_rdata;

	logic mem_en, mem_rw, mem_ack;
	logic [`LSU_DATA_W-1:0] mem_addr, mem_wdata, mem_rdata;
	logic [3:0] mem_mask;

	// Order only shapes load data inside each port
	ldst_port u_port_0 (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.issue_valid(issue_valid_0), .cmd(cmd_0),
		.source0(source0_0), .source1(source1_0),
		.commit_tag(commit_tag_0), .dest_reg(dest_reg_0),
		.bus_busy(bus_busy_0), .bus_ack(bus_ack_0), .bus_rdata(bus_rdata),
		.lock(lock_0), .done(done_0), .done_tag(done_tag_0),
		.done_reg(done_reg_0), .writeback(writeback_0),
		.done_data(done_data_0), .spr(spr_0),
		.bus_req(bus_req_0), .bus_rw(bus_rw_0), .bus_addr(bus_addr_0),
		.bus_data(bus_data_0), .bus_mask(bus_mask_0), .bus_order()
	);

	ldst_port u_port_1 (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.issue_valid(issue_valid_1), .cmd(cmd_1),
		.source0(source0_1), .source1(source1_1),
		.commit_tag(commit_tag_1), .dest_reg(dest_reg_1),
		.bus_busy(bus_busy_1), .bus_ack(bus_ack_1), .bus_rdata(bus_rdata),
		.lock(lock_1), .done(done_1), .done_tag(done_tag_1),
		.done_reg(done_reg_1), .writeback(writeback_1),
		.done_data(done_data_1), .spr(spr_1),
		.bus_req(bus_req_1), .bus_rw(bus_rw_1), .bus_addr(bus_addr_1),
		.bus_data(bus_data_1), .bus_mask(bus_mask_1), .bus_order()
	);

	data_bus_arbiter u_arbiter (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.req0(bus_req_0), .req1(bus_req_1),
		.rw0(bus_rw_0), .rw1(bus_rw_1),
		.addr0(bus_addr_0), .addr1(bus_addr_1),
		.data0(bus_data_0), .data1(bus_data_1),
		.mask0(bus_mask_0), .mask1(bus_mask_1),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata),
		.busy0(bus_busy_0), .busy1(bus_busy_1),
		.ack0(bus_ack_0), .ack1(bus_ack_1), .rdata(bus_rdata),
		.mem_en(mem_en), .mem_rw(mem_rw), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_mask(mem_mask)
	);

	data_memory u_memory (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.mem_en(mem_en), .mem_rw(mem_rw), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_mask(mem_mask),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// File: testbench/lsu_properties.sv
// Bus and port protocol assertions
// Attached to the arbiter and to each load/store port by bind
`timescale 1ns/100ps
`default_nettype none

module lsu_properties (
	input wire iCLOCK,
	input wire inRESET,
	input wire req_en,
	input wire req_ack,
	input wire grant_a,
	input wire grant_b,
	input wire ack_a,
	input wire ack_b,
	input wire issue,
	input wire done
);

	// Set by an issue, cleared by its done
	logic b_open;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_open <= 1'b0;
		end else if (issue) begin
			b_open <= 1'b1;
		end else if (done) begin
			b_open <= 1'b0;
		end
	end

	// Memory answers exactly one cycle after each access
	ack_follows_en: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		req_en |=> req_ack) else $error("mem_ack missing one cycle after mem_en");

	ack_has_en: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		req_ack |-> $past(req_en)) else $error("mem_ack without mem_en one cycle before");

	// At most one port wins the bus, and each ack goes to the port accepted before
	one_grant: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(grant_a && grant_b)) else $error("both ports accepted in one cycle");

	ack_a_owner: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ack_a |-> $past(grant_a)) else $error("port 0 acked without an accepted request");

	ack_b_owner: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ack_b |-> $past(grant_b)) else $error("port 1 acked without an accepted request");

	no_idle_done: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		done |-> b_open) else $error("done raised while the port is idle");

endmodule

bind data_bus_arbiter lsu_properties u_arbiter_props (
	.iCLOCK(iCLOCK), .inRESET(inRESET), .req_en(mem_en), .req_ack(mem_ack),
	.grant_a(req0 && !busy0), .grant_b(req1 && !busy1),
	.ack_a(ack0), .ack_b(ack1), .issue(1'b0), .done(1'b0)
);

bind ldst_port lsu_properties u_port_props (
	.iCLOCK(iCLOCK), .inRESET(inRESET), .req_en(1'b0), .req_ack(1'b0),
	.grant_a(1'b0), .grant_b(1'b0), .ack_a(1'b0), .ack_b(1'b0),
	.issue(issue_valid && !lock), .done(done)
);

`default_nettype wire

// File: testbench/tb_lsu_top.sv
// Testbench for the load/store subsystem
// Random commands on both ports, checked against a memory and SPR model
`timescale 1ns/100ps
`default_nettype none
`include "lsu_macros.svh"

module tb_lsu_top
	import lsu_cmd_pkg::*;
;

	localparam int CLK_PERIOD = 100;
	localparam int N_CMDS = 200;
	localparam int INIT_WORDS = 16;
	localparam longint TIMEOUT = (2 * N_CMDS * 20 + 10) * CLK_PERIOD;

	typedef struct packed {
		ldst_cmd_t cmd;
		commit_tag_t tag;
		logic [`LSU_REG_W-1:0] dreg;
		logic wb;
		logic [`LSU_DATA_W-1:0] data;
		logic [`LSU_DATA_W-1:0] spr;
		logic [63:0] t_issue;
	} expect_t;

	logic iCLOCK;
	logic inRESET;
	logic [1:0] issue_valid;
	ldst_cmd_t cmd [2];
	logic [`LSU_DATA_W-1:0] source0 [2];
	logic [`LSU_DATA_W-1:0] source1 [2];
	commit_tag_t commit_tag [2];
	logic [`LSU_REG_W-1:0] dest_reg [2];
	logic [1:0] lock;
	logic [1:0] done;
	logic [1:0] writeback;
	commit_tag_t done_tag [2];
	logic [`LSU_REG_W-1:0] done_reg [2];
	logic [`LSU_DATA_W-1:0] done_data [2];
	logic [`LSU_DATA_W-1:0] spr [2];

	// Model state, updated in issue order per port
	logic [`LSU_DATA_W-1:0] model_mem [`LSU_MEM_WORDS];
	logic [`LSU_DATA_W-1:0] model_spr [2];
	int depth [2];
	int n_issued [2];
	int n_done [2];
	expect_t exp_q [2][$];
	logic [31:0] rng;

	lsu_top u_lsu_top (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.issue_valid_0(issue_valid[0]), .cmd_0(cmd[0]),
		.source0_0(source0[0]), .source1_0(source1[0]),
		.commit_tag_0(commit_tag[0]), .dest_reg_0(dest_reg[0]),
		.lock_0(lock[0]), .done_0(done[0]), .done_tag_0(done_tag[0]),
		.done_reg_0(done_reg[0]), .writeback_0(writeback[0]),
		.done_data_0(done_data[0]), .spr_0(spr[0]),
		.issue_valid_1(issue_valid[1]), .cmd_1(cmd[1]),
		.source0_1(source0[1]), .source1_1(source1[1]),
		.commit_tag_1(commit_tag[1]), .dest_reg_1(dest_reg[1]),
		.lock_1(lock[1]), .done_1(done[1]), .done_tag_1(done_tag[1]),
		.done_reg_1(done_reg[1]), .writeback_1(writeback[1]),
		.done_data_1(done_data[1]), .spr_1(spr[1])
	);

	always #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Expected done data of one command; also applies it to the model
	function automatic logic [`LSU_DATA_W-1:0] ref_result(input int p, input ldst_cmd_t c,
		input logic [`LSU_DATA_W-1:0] s0, input logic [`LSU_DATA_W-1:0] s1);
		logic [`LSU_DATA_W-1:0] w;
		logic [`LSU_DATA_W-1:0] res;
		w = model_mem[s1[9:2]];
		res = '0;
		case (c)
			LD_BYTE: res = {24'h0, w[{s1[1:0], 3'b000} +: 8]};
			LD_HALF: res = {16'h0, w[{s1[1], 4'b0000} +: 16]};
			LD_WORD: res = w;
			ST_BYTE: model_mem[s1[9:2]][{s1[1:0], 3'b000} +: 8] = s0[7:0];
			ST_HALF: model_mem[s1[9:2]][{s1[1], 4'b0000} +: 16] = s0[15:0];
			ST_WORD: model_mem[s1[9:2]] = s0;
			PUSH: begin
				model_spr[p] = model_spr[p] - 32'd4;
				model_mem[model_spr[p][9:2]] = s0;
				depth[p] = depth[p] + 1;
			end
			POP: begin
				res = model_mem[model_spr[p][9:2]];
				model_spr[p] = model_spr[p] + 32'd4;
				depth[p] = depth[p] - 1;
			end
			WRITE_SPR: begin
				model_spr[p] = s0;
				depth[p] = 0;
			end
			default: res = '0;
		endcase
		return res;
	endfunction

	task automatic report_fail(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "check failed");
	endtask

	task automatic check_data(input string name, input logic [`LSU_DATA_W-1:0] exp_v,
		input logic [`LSU_DATA_W-1:0] act_v);
		if (act_v !== exp_v) begin
			report_fail($sformatf("** Error: %s expected %h actual %h", name, exp_v, act_v));
		end
	endtask

	task automatic check_tag(input string name, input commit_tag_t exp_v,
		input commit_tag_t act_v);
		if (act_v !== exp_v) begin
			report_fail($sformatf("** Error: %s expected %h actual %h", name, exp_v, act_v));
		end
	endtask

	task automatic check_spr(input string name, input logic [`LSU_DATA_W-1:0] exp_v,
		input logic [`LSU_DATA_W-1:0] act_v);
		if (act_v !== exp_v) begin
			report_fail($sformatf("** Error: %s expected %h actual %h", name, exp_v, act_v));
		end
	endtask

	task automatic check_flag(input string name, input logic exp_v, input logic act_v);
		if (act_v !== exp_v) begin
			report_fail($sformatf("** Error: %s expected %b actual %b", name, exp_v, act_v));
		end
	endtask

	// Port 0 keeps to the lower half of memory, port 1 to the upper half
	task automatic present_command(input int p);
		logic [31:0] r;
		logic [31:0] data_base;
		logic [31:0] stack_base;
		ldst_cmd_t c;
		int idx;
		r = next_rand();
		idx = n_issued[p];
		data_base = (p == 1) ? 32'h200 : 32'h000;
		stack_base = (p == 1) ? 32'h3c0 : 32'h1c0;
		c = ldst_cmd_t'(4'(r % 32'd9));
		if (idx == 0) begin
			c = WRITE_SPR;
		end else if (idx <= INIT_WORDS) begin
			c = ST_WORD;
		end else if (c == PUSH && depth[p] >= 12) begin
			c = ST_WORD;
		end else if (c == POP && depth[p] == 0) begin
			c = LD_WORD;
		end else if (c == WRITE_SPR && depth[p] != 0) begin
			c = LD_BYTE;
		end
		cmd[p] <= c;
		source0[p] <= next_rand();
		case (c)
			LD_BYTE, ST_BYTE: source1[p] <= data_base + {26'h0, r[13:8]};
			LD_HALF, ST_HALF: source1[p] <= data_base + {26'h0, r[13:9], 1'b0};
			default: source1[p] <= data_base + {26'h0, r[13:10], 2'b00};
		endcase
		if (idx >= 1 && idx <= INIT_WORDS) begin
			source1[p] <= data_base + 32'((idx - 1) * 4);
		end
		if (c == WRITE_SPR) begin
			source0[p] <= stack_base - {26'h0, r[17:16], 4'h0};
		end
		commit_tag[p] <= {p[0], idx[4:0]};
		dest_reg[p] <= r[23:18];
		issue_valid[p] <= 1'b1;
	endtask

	// Record each taken issue in the model, then offer the next command
	always @(posedge iCLOCK) begin
		if (inRESET) begin
			for (int p = 0; p < 2; p++) begin
				expect_t e;
				if (issue_valid[p] && !lock[p]) begin
					e.cmd = cmd[p];
					e.tag = commit_tag[p];
					e.dreg = dest_reg[p];
					e.wb = cmd[p] inside {LD_BYTE, LD_HALF, LD_WORD, POP};
					e.data = ref_result(p, cmd[p], source0[p], source1[p]);
					e.spr = model_spr[p];
					e.t_issue = $time;
					exp_q[p].push_back(e);
					n_issued[p] = n_issued[p] + 1;
				end
				if (!(issue_valid[p] && lock[p])) begin
					if (n_issued[p] < N_CMDS) begin
						present_command(p);
					end else begin
						issue_valid[p] <= 1'b0;
					end
				end
			end
		end
	end

	// Compare every done pulse with the oldest open command of its port
	always @(negedge iCLOCK) begin
		if (inRESET) begin
			for (int p = 0; p < 2; p++) begin
				expect_t e;
				if (done[p]) begin
					if (exp_q[p].size() == 0) begin
						report_fail($sformatf("Port %0d signalled done with no command open", p));
					end
					e = exp_q[p].pop_front();
					check_tag($sformatf("port%0d done_tag", p), e.tag, done_tag[p]);
					check_data($sformatf("port%0d done_reg", p), 32'(e.dreg), 32'(done_reg[p]));
					check_flag($sformatf("port%0d writeback", p), e.wb, writeback[p]);
					if (e.wb) begin
						check_data($sformatf("port%0d done_data", p), e.data, done_data[p]);
					end
					check_spr($sformatf("port%0d spr", p), e.spr, spr[p]);
					if (e.cmd == WRITE_SPR && ($time - e.t_issue) != 64'(CLK_PERIOD * 3 / 2)) begin
						report_fail($sformatf("Port %0d WRITE_SPR done not 2 cycles after issue", p));
					end
					n_done[p] = n_done[p] + 1;
				end
			end
		end
	end

	initial begin
		#(TIMEOUT);
		$display("Watchdog expired before all commands completed");
		$display("Test failed");
		$fatal(1, "timeout");
	end

	initial begin
		rng = 32'h1609_26a5;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		issue_valid = 2'b00;
		for (int p = 0; p < 2; p++) begin
			cmd[p] = LD_WORD;
			source0[p] = '0;
			source1[p] = '0;
			commit_tag[p] = '0;
			dest_reg[p] = '0;
			model_spr[p] = '0;
			depth[p] = 0;
			n_issued[p] = 0;
			n_done[p] = 0;
		end
		repeat (2) @(posedge iCLOCK);
		inRESET <= 1'b1;
		@(negedge iCLOCK);
		check_spr("reset spr_0", '0, spr[0]);
		check_spr("reset spr_1", '0, spr[1]);
		wait (n_done[0] == N_CMDS && n_done[1] == N_CMDS);
		repeat (4) @(posedge iCLOCK);
		// Both ports idle and the bus free once all commands are done
		if (lock == 2'b00) begin
			$display("Test passed");
		end else begin
			$display("Ports still locked after all commands completed");
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: lsu.f
+incdir+verilog
verilog/lsu_cmd_pkg.sv
verilog/lsu_bus_pkg.sv
verilog/ldst_address_gen.sv
verilog/ldst_port.sv
verilog/data_bus_arbiter.sv
verilog/data_memory.sv
verilog/lsu_top.sv
testbench/lsu_properties.sv
testbench/tb_lsu_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the load/store testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_lsu_top -f lsu.f -o sim_lsu
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_lsu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
